/* eeprom_wr.f */
design/eeprom_pkg.sv
design/i2c_bit_if.sv
design/i2c_bit_engine.sv
design/eeprom_sequencer.sv
design/eeprom_wr.sv
tb/eeprom_model.sv
tb/eeprom_wr_tb.sv

/* Makefile */
SRCS := $(wildcard design/*.sv tb/*.sv)

obj_dir/Veeprom_wr_tb: $(SRCS) eeprom_wr.f
	verilator --binary --timing --top-module eeprom_wr_tb -f eeprom_wr.f

.PHONY: run clean

run: obj_dir/Veeprom_wr_tb
	./obj_dir/Veeprom_wr_tb | tee /dev/stderr | grep -qx "all tests passed"

clean:
	rm -rf obj_dir

/* tb/eeprom_wr_tb.sv */
`timescale 1ns/100ps

module eeprom_wr_tb;
    import eeprom_pkg::*;

    localparam int CLK_DIV        = 4;
    localparam int N_ROWS         = 13;
    localparam int TIMEOUT_CYCLES = N_ROWS * 40 * 2 * CLK_DIV * 2;

    typedef struct packed
    {
        op_e   op;
        addr_t addr;
        data_t wdata;
        logic  ack_en;
        logic  chk_data;
        data_t exp_rdata;
        logic  exp_nack;
        logic  double_wr;   // extra wr pulse while busy
    } row_t;

    logic        CLK, RESET, wr, rd, done, nack, busy, scl, ack_en;
    addr_t       addr;
    data_t       wdata, rdata;
    wire         sda;
    logic [15:0] lfsr = 16'd17;
    row_t        rows [$];
    int          errors = 0;
    int          passed = 0;
    int          cycles = 0;

    eeprom_wr #(.CLK_DIV(CLK_DIV)) i_dut (.*);
    eeprom_model i_mem (.*);

    initial
    begin
        CLK = 1'b0;
        forever
            #20 CLK = ~CLK;
    end

    initial
    begin
        while (cycles < TIMEOUT_CYCLES)
        begin
            @(posedge CLK);
            cycles++;
        end
        $display("timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
        $display("tests failed");
        $finish;
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [15:0] draw(input int n);
        logic [15:0] v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr_step(lfsr);
            v    = {v[14:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic check_data(input string name, input data_t got, input data_t exp);
        if (got !== exp)
        begin
            $display("mismatch at %0t: %s is %02h, expected %02h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("mismatch at %0t: %s is %0b, expected %0b", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic add_row(input op_e op, input addr_t a, input data_t d, input logic ack,
                           input logic chk, input data_t exp_d, input logic exp_n,
                           input logic dbl);
        rows.push_back(row_t'{op, a, d, ack, chk, exp_d, exp_n, dbl});
    endtask

    task automatic build_table();
        addr_t a0, a1, a2, a3, a4;
        data_t d0, d1, d2, d3, d4;
        a0 = addr_t'(draw(11));
        a1 = {a0[10:8] ^ 3'b101, a0[7:0]};     // same low byte, other block
        a2 = {a0[10:8] ^ 3'b010, a0[7:0]};
        a3 = {a0[10:8] ^ 3'b111, a0[7:0]};     // never written
        a4 = {~a3[10], 10'(draw(10))};
        d0 = data_t'(draw(8));
        d1 = d0 ^ data_t'({draw(7), 1'b1});
        d2 = d0 ^ data_t'({draw(6), 2'b10});
        d3 = data_t'(draw(7));
        d4 = data_t'(draw(8));
        add_row(op_write, a0, d0,    1'b1, 1'b0, 8'h00, 1'b0, 1'b0);
        add_row(op_read,  a0, 8'h00, 1'b1, 1'b1, d0,    1'b0, 1'b0);
        add_row(op_write, a1, d1,    1'b1, 1'b0, 8'h00, 1'b0, 1'b0);
        add_row(op_write, a2, d2,    1'b1, 1'b0, 8'h00, 1'b0, 1'b0);
        add_row(op_read,  a3, 8'h00, 1'b1, 1'b1, 8'hff, 1'b0, 1'b0);
        add_row(op_read,  a0, 8'h00, 1'b1, 1'b1, d0,    1'b0, 1'b0);
        add_row(op_read,  a1, 8'h00, 1'b1, 1'b1, d1,    1'b0, 1'b0);
        add_row(op_read,  a2, 8'h00, 1'b1, 1'b1, d2,    1'b0, 1'b0);
        add_row(op_write, a3, d3,    1'b0, 1'b0, 8'h00, 1'b1, 1'b0);
        add_row(op_read,  a0, 8'h00, 1'b0, 1'b1, d2,    1'b1, 1'b0);  // rdata kept
        add_row(op_read,  a3, 8'h00, 1'b1, 1'b1, 8'hff, 1'b0, 1'b0);
        add_row(op_write, a4, d4,    1'b1, 1'b0, 8'h00, 1'b0, 1'b1);
        add_row(op_read,  a4, 8'h00, 1'b1, 1'b1, d4,    1'b0, 1'b0);
    endtask

    task automatic apply_row(input int idx);
        row_t r;
        int   err_before;
        logic extra;
        r          = rows[idx];
        err_before = errors;
        extra      = 1'b0;
        ack_en     = r.ack_en;
        addr       = r.addr;
        wdata      = r.wdata;
        wr         = (r.op == op_write);
        rd         = (r.op == op_read);
        @(negedge CLK);
        wr = 1'b0;
        rd = 1'b0;
        check_flag("busy", busy, 1'b1);
        if (r.double_wr)
        begin
            repeat (3) @(negedge CLK);
            wdata = ~r.wdata;
            wr    = 1'b1;
            @(negedge CLK);
            wr = 1'b0;
        end
        while (!done)
            @(negedge CLK);
        check_flag("busy", busy, 1'b0);
        check_flag("nack", nack, r.exp_nack);
        if (r.chk_data)
            check_data("rdata", rdata, r.exp_rdata);
        repeat (4 * CLK_DIV)
        begin
            @(negedge CLK);
            extra = extra | done | busy;
        end
        if (extra)
        begin
            $display("row %0d: a second operation started after done", idx);
            errors++;
        end
        if (errors == err_before)
            passed++;
        $display("row %0d %s addr %03h ack_en %0b: %s", idx,
                 r.op == op_write ? "write" : "read ", r.addr, r.ack_en,
                 errors == err_before ? "ok   " : "error");
    endtask

    initial
    begin
        RESET  = 1'b1;
        wr     = 1'b0;
        rd     = 1'b0;
        addr   = '0;
        wdata  = '0;
        ack_en = 1'b1;
        build_table();
        repeat (2) @(negedge CLK);
        RESET = 1'b0;
        @(negedge CLK);
        check_flag("scl", scl, 1'b1);
        check_flag("sda", sda, 1'b1);   // released, pullup only
        check_flag("busy", busy, 1'b0);
        check_flag("done", done, 1'b0);
        check_flag("nack", nack, 1'b0);
        if (errors == 0)
            passed++;
        $display("reset state: %s", errors == 0 ? "ok   " : "error");
        for (int i = 0; i < rows.size(); i++)
            apply_row(i);
        $display("%0d of %0d tests ok, %0d errors", passed, N_ROWS + 1, errors);
        if (errors == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

/* tb/eeprom_model.sv */
`timescale 1ns/100ps

module eeprom_model (
    input logic scl,
    inout wire  sda,
    input logic ack_en
);
    import eeprom_pkg::*;

    typedef enum logic [2:0] {m_idle, m_ctrl, m_addr, m_wdata, m_rdata} phase_e;

    data_t      mem [0:2047];
    phase_e     phase     = m_idle;
    addr_t      ptr       = '0;
    logic [2:0] blk       = '0;     // block bits from the control byte
    logic [3:0] bit_cnt   = '0;
    data_t      shreg     = '0;
    logic       drive_low = 1'b0;
    logic       prev_scl  = 1'b1;
    logic       prev_sda  = 1'b1;

    pullup (sda);
    assign sda = drive_low ? 1'b0 : 1'bz;

    // byte boundaries, ack slot and read data, all on scl falling
    task scl_fall();
        if (bit_cnt == 4'd8 && phase == m_rdata)
            drive_low = 1'b0;       // master owns the ack slot
        else if (bit_cnt == 4'd8)
        begin
            if (ack_en && (phase != m_ctrl || shreg[7:4] == CTRL_CODE))
            begin
                drive_low = 1'b1;
                case (phase)
                    m_ctrl:
                    begin
                        blk   = shreg[3:1];
                        phase = shreg[0] ? m_rdata : m_addr;
                    end
                    m_addr:
                    begin
                        ptr   = {blk, shreg};
                        phase = m_wdata;
                    end
                    default:
                    begin
                        mem[ptr] = shreg;
                        ptr      = ptr + 1'b1;
                    end
                endcase
            end
            else
                phase = m_idle;     // no ack, wait for the next start
        end
        else if (bit_cnt == 4'd9)
        begin
            bit_cnt   = '0;
            drive_low = 1'b0;
            if (phase == m_rdata)
            begin
                shreg     = mem[ptr];
                ptr       = ptr + 1'b1;
                drive_low = ~shreg[7];
            end
        end
        else if (phase == m_rdata && bit_cnt != 4'd0)
            drive_low = ~shreg[7];  // shifted, next bit sits at the top
    endtask

    initial
    begin
        for (int i = 0; i < 2048; i++)
            mem[i] = 8'hff;
        forever
        begin
            @(scl or sda);
            #1;     // scl and sda may move in the same step
            if (prev_scl && scl && prev_sda != sda)
            begin
                phase   = sda ? m_idle : m_ctrl;    // stop or start
                bit_cnt = '0;
            end
            else if (!prev_scl && scl && phase != m_idle)
            begin
                if (bit_cnt < 4'd8)
                    shreg = {shreg[6:0], sda};
                else if (phase == m_rdata && sda)
                    phase = m_idle;                 // master nack
                bit_cnt = bit_cnt + 4'd1;
            end
            else if (prev_scl && !scl && phase != m_idle)
                scl_fall();
            prev_scl = scl;
            prev_sda = sda;
        end
    end

endmodule

/* design/eeprom_wr.sv */
`timescale 1ns/100ps

module eeprom_wr #(
    parameter int CLK_DIV = 4       // clk cycles per scl half period
) (
    input  logic              CLK,
    input  logic              RESET,
    input  logic              wr,
    input  logic              rd,
    input  eeprom_pkg::addr_t addr,
    input  eeprom_pkg::data_t wdata,
    output eeprom_pkg::data_t rdata,
    output logic              done,
    output logic              nack,
    output logic              busy,
    output logic              scl,
    inout  wire               sda
);
    logic sda_low;
    logic sda_in;

    i2c_bit_if bit_if ();

    eeprom_sequencer u_seq
    (
        .CLK    (CLK),
        .RESET  (RESET),
        .wr     (wr),
        .rd     (rd),
        .addr   (addr),
        .wdata  (wdata),
        .rdata  (rdata),
        .done   (done),
        .nack   (nack),
        .busy   (busy),
        .bit_if (bit_if)
    );

    i2c_bit_engine #(
        .CLK_DIV (CLK_DIV)
    ) u_engine
    (
        .CLK     (CLK),
        .RESET   (RESET),
        .sda_in  (sda_in),
        .scl     (scl),
        .sda_low (sda_low),
        .bit_if  (bit_if)
    );

    // open drain, high level comes from the external pullup
    assign sda    = sda_low ? 1'b0 : 1'bz;
    assign sda_in = sda;

endmodule

/* design/eeprom_sequencer.sv */
`timescale 1ns/100ps

module eeprom_sequencer (
    input  logic              CLK,
    input  logic              RESET,
    input  logic              wr,
    input  logic              rd,
    input  eeprom_pkg::addr_t addr,
    input  eeprom_pkg::data_t wdata,
    output eeprom_pkg::data_t rdata,
    output logic              done,
    output logic              nack,
    output logic              busy,
    i2c_bit_if.seq            bit_if
);
    import eeprom_pkg::*;

    typedef enum logic [3:0]
    {
        s_idle,
        s_start,
        s_ctrl,
        s_addr,
        s_data,
        s_restart,
        s_ctrl_rd,
        s_read,
        s_stop,
        s_done
    } seq_state_e;

    seq_state_e state;
    op_e        op;
    addr_t      addr_r;
    data_t      wdata_r;
    data_t      rdata_r;
    logic       issued;     // command of the current state is out
    logic       busy_r;
    logic       done_r;
    logic       nack_r;
    logic       cmd_valid_r;
    bit_cmd_e   cmd_r;
    data_t      tx_r;
    bit_cmd_e   next_cmd;
    data_t      next_tx;
    logic       byte_sent;

    // bytes that expect a slave ack
    assign byte_sent = (state == s_ctrl) || (state == s_addr) ||
                       (state == s_data) || (state == s_ctrl_rd);

    always_comb
    begin
        next_cmd = cmd_write;
        next_tx  = 8'hff;
        case (state)
            s_start, s_restart:
                next_cmd = cmd_start;
            s_stop:
                next_cmd = cmd_stop;
            s_ctrl:
                next_tx = {CTRL_CODE, addr_r[10:8], 1'b0};    // write direction
            s_addr:
                next_tx = addr_r[7:0];
            s_data:
                next_tx = wdata_r;
            s_ctrl_rd:
                next_tx = {CTRL_CODE, addr_r[10:8], 1'b1};
            s_read:
                next_cmd = cmd_read;
            default:
                next_cmd = cmd_write;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state       <= s_idle;
            op          <= op_write;
            issued      <= 1'b0;
            busy_r      <= 1'b0;
            done_r      <= 1'b0;
            nack_r      <= 1'b0;
            cmd_valid_r <= 1'b0;
        end
        else
        begin
            done_r      <= 1'b0;
            cmd_valid_r <= 1'b0;
            case (state)
                s_idle:
                begin
                    if (wr || rd)
                    begin
                        op      <= wr ? op_write : op_read;   // write wins
                        addr_r  <= addr;
                        wdata_r <= wdata;
                        nack_r  <= 1'b0;
                        busy_r  <= 1'b1;
                        issued  <= 1'b0;
                        state   <= s_start;
                    end
                end

                s_done:
                begin
                    done_r <= 1'b1;
                    busy_r <= 1'b0;
                    state  <= s_idle;
                end

                default:
                begin
                    if (!issued)
                    begin
                        cmd_valid_r <= 1'b1;
                        cmd_r       <= next_cmd;
                        tx_r        <= next_tx;
                        issued      <= 1'b1;
                    end
                    else if (bit_if.done)
                    begin
                        issued <= 1'b0;
                        if (byte_sent && !bit_if.ack_ok)
                        begin
                            nack_r <= 1'b1;   // abort with a stop
                            state  <= s_stop;
                        end
                        else
                        begin
                            case (state)
                                s_start:   state <= s_ctrl;
                                s_ctrl:    state <= s_addr;
                                s_addr:    state <= (op == op_write) ? s_data : s_restart;
                                s_data:    state <= s_stop;
                                s_restart: state <= s_ctrl_rd;
                                s_ctrl_rd: state <= s_read;
                                s_read:
                                begin
                                    rdata_r <= bit_if.rx_byte;
                                    state   <= s_stop;
                                end
                                s_stop:    state <= s_done;
                                default:   state <= s_idle;
                            endcase
                        end
                    end
                end
            endcase
        end
    end

    assign bit_if.cmd       = cmd_r;
    assign bit_if.cmd_valid = cmd_valid_r;
    assign bit_if.tx_byte   = tx_r;

    assign rdata = rdata_r;
    assign done  = done_r;
    assign nack  = nack_r;
    assign busy  = busy_r;

endmodule

/* design/i2c_bit_engine.sv */
`timescale 1ns/100ps

module i2c_bit_engine #(
    parameter int CLK_DIV = 4
) (
    input  logic      CLK,
    input  logic      RESET,
    input  logic      sda_in,
    output logic      scl,
    output logic      sda_low,
    i2c_bit_if.engine bit_if
);
    import eeprom_pkg::*;

    localparam int CW = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;
    localparam logic [CW-1:0] LAST = CW'(CLK_DIV - 1);
    localparam logic [CW-1:0] MID  = CW'((CLK_DIV - 1) / 2);  // middle of scl high

    typedef enum logic [2:0]
    {
        eng_idle,
        eng_start,
        eng_stop,
        eng_write,
        eng_read,
        eng_end
    } eng_state_e;

    eng_state_e    state;
    logic [CW-1:0] div_cnt;
    logic          high_half;   // scl high part of the bit
    logic [3:0]    bit_cnt;     // 0..7 data, 8 ack slot
    data_t         shreg;
    logic          ack_r;
    logic          done_r;
    logic          scl_r;
    logic          sda_low_r;
    logic          half_end;
    logic          mid_point;
    logic          last_bit;

    assign half_end  = (div_cnt == LAST);
    assign mid_point = high_half && (div_cnt == MID);
    assign last_bit  = (state == eng_start) || (state == eng_stop) || (bit_cnt == 4'd8);

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state     <= eng_idle;
            div_cnt   <= '0;
            high_half <= 1'b0;
            bit_cnt   <= '0;
            ack_r     <= 1'b0;
            done_r    <= 1'b0;
            scl_r     <= 1'b1;    // bus idle
            sda_low_r <= 1'b0;
        end
        else
        begin
            done_r <= 1'b0;
            case (state)
                eng_idle:
                begin
                    if (bit_if.cmd_valid)
                    begin
                        div_cnt   <= '0;
                        high_half <= 1'b0;
                        bit_cnt   <= '0;
                        ack_r     <= 1'b1;
                        scl_r     <= 1'b0;
                        shreg     <= bit_if.tx_byte;
                        case (bit_if.cmd)
                            cmd_start:
                            begin
                                state     <= eng_start;
                                sda_low_r <= 1'b0;    // release before the high half
                            end
                            cmd_stop:
                            begin
                                state     <= eng_stop;
                                sda_low_r <= 1'b1;
                            end
                            cmd_write:
                            begin
                                state     <= eng_write;
                                sda_low_r <= ~bit_if.tx_byte[7];  // msb first
                            end
                            default:
                            begin
                                state     <= eng_read;
                                sda_low_r <= 1'b0;
                            end
                        endcase
                    end
                end

                eng_start, eng_stop, eng_write, eng_read:
                begin
                    if (mid_point)
                    begin
                        case (state)
                            eng_start:
                                sda_low_r <= 1'b1;    // sda falls with scl high
                            eng_stop:
                                sda_low_r <= 1'b0;    // sda rises with scl high
                            default:
                            begin
                                if (bit_cnt < 4'd8)
                                    shreg <= {shreg[6:0], sda_in};
                                else if (state == eng_write)
                                    ack_r <= ~sda_in;
                            end
                        endcase
                    end

                    if (half_end)
                    begin
                        div_cnt <= '0;
                        if (!high_half)
                        begin
                            high_half <= 1'b1;
                            scl_r     <= 1'b1;
                        end
                        else
                        begin
                            high_half <= 1'b0;
                            if (last_bit)
                            begin
                                state <= eng_end;
                                if (state != eng_stop)
                                    scl_r <= 1'b0;  // stop leaves scl high
                            end
                            else
                            begin
                                scl_r   <= 1'b0;
                                bit_cnt <= bit_cnt + 4'd1;
                                // next data bit, or release for ack / nack slot
                                if (state == eng_write && bit_cnt < 4'd7)
                                    sda_low_r <= ~shreg[7];
                                else
                                    sda_low_r <= 1'b0;
                            end
                        end
                    end
                    else
                    begin
                        div_cnt <= div_cnt + 1'b1;
                    end
                end

                eng_end:
                begin
                    done_r <= 1'b1;   // one cycle after the last scl fall
                    state  <= eng_idle;
                end

                default:
                    state <= eng_idle;
            endcase
        end
    end

    assign scl            = scl_r;
    assign sda_low        = sda_low_r;
    assign bit_if.done    = done_r;
    assign bit_if.rx_byte = shreg;
    assign bit_if.ack_ok  = ack_r;

endmodule

/* design/i2c_bit_if.sv */
`timescale 1ns/100ps

interface i2c_bit_if;
    import eeprom_pkg::*;

    bit_cmd_e cmd;
    logic     cmd_valid;    // one cycle, engine must be idle
    data_t    tx_byte;
    logic     done;         // bus phase finished
    data_t    rx_byte;
    logic     ack_ok;       // slave pulled sda low in the ack slot

    modport seq
    (
        output cmd,
        output cmd_valid,
        output tx_byte,
        input  done,
        input  rx_byte,
        input  ack_ok
    );

    modport engine
    (
        input  cmd,
        input  cmd_valid,
        input  tx_byte,
        output done,
        output rx_byte,
        output ack_ok
    );

endinterface

/* design/eeprom_pkg.sv */
package eeprom_pkg;

    // 24c16 style array, 2048 bytes
    typedef logic [10:0] addr_t;

    typedef logic [7:0] data_t;

    // host request kind
    typedef enum logic
    {
        op_write = 1'b0,
        op_read  = 1'b1
    } op_e;

    // command set of the bit engine
    typedef enum logic [1:0]
    {
        cmd_start = 2'd0,   // start or repeated start
        cmd_stop  = 2'd1,
        cmd_write = 2'd2,   // byte out, slave ack sampled
        cmd_read  = 2'd3    // byte in, answered with nack
    } bit_cmd_e;

    // device type code in the upper nibble of the control byte
    localparam logic [3:0] CTRL_CODE = 4'b1010;

endpackage
